// File: files.f
+incdir+rtl
rtl/renamePkg.sv
rtl/opQueue.sv
rtl/freeList.sv
rtl/registerAliasTable.sv
rtl/renameStage.sv
rtl/renameUnit.sv
testbench/renameUnitTb.sv

// File: rtl/freeList.sv
`timescale 1ns/10ps
`default_nettype none
`include "rename_defines.svh"

module freeList (
    input  wire logic                CLK,
    input  wire logic                reset,
    input  wire logic                allocate,
    output renamePkg::physReg_t      freeReg,
    output logic                     empty,
    input  wire logic                releaseValid,
    input  wire renamePkg::physReg_t releaseReg
);

    import renamePkg::*;

    // Registers not held by the table at any one time
    localparam int FREE_COUNT = `NUM_PHYS_REGS - `NUM_ARCH_REGS;
    localparam int PTR_BITS   = $clog2(FREE_COUNT);
    localparam int COUNT_BITS = $clog2(FREE_COUNT + 1);
    localparam logic [PTR_BITS-1:0] LAST_PTR = PTR_BITS'(FREE_COUNT - 1);

    physReg_t              entries [FREE_COUNT];
    logic [PTR_BITS-1:0]   headPtr;
    logic [PTR_BITS-1:0]   tailPtr;
    logic [COUNT_BITS-1:0] count;
    logic                  doAllocate;

    assign doAllocate = allocate && !empty;
    assign empty      = (count == '0);
    assign freeReg    = entries[headPtr];

    // ------------------------------------------------------------------------
    // Starts full with the registers above the architectural range
    // ------------------------------------------------------------------------
    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int i = 0; i < FREE_COUNT; i++) begin
                entries[i] <= physReg_t'(`NUM_ARCH_REGS + i);
            end
            headPtr <= '0;
            tailPtr <= '0;
            count   <= COUNT_BITS'(FREE_COUNT);
        end else begin
            // Retired registers go to the tail in retire order
            if (releaseValid) begin
                entries[tailPtr] <= releaseReg;
                tailPtr          <= (tailPtr == LAST_PTR) ? '0 : tailPtr + 1'b1;
            end
            if (doAllocate) begin
                headPtr <= (headPtr == LAST_PTR) ? '0 : headPtr + 1'b1;
            end
            if (releaseValid && !doAllocate) begin
                count <= count + 1'b1;
            end else if (doAllocate && !releaseValid) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/opQueue.sv
`timescale 1ns/10ps
`default_nettype none

module opQueue #(
    parameter int DEPTH      = 8,
    parameter int ENTRY_BITS = 32
) (
    input  wire logic                  CLK,
    input  wire logic                  reset,
    input  wire logic                  push,
    input  wire logic [ENTRY_BITS-1:0] pushData,
    output logic                       full,
    input  wire logic                  pop,
    output logic      [ENTRY_BITS-1:0] popData,
    output logic                       empty
);

    localparam int PTR_BITS   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_BITS = $clog2(DEPTH + 1);
    localparam logic [PTR_BITS-1:0] LAST_PTR = PTR_BITS'(DEPTH - 1);

    logic [ENTRY_BITS-1:0] entries [DEPTH];
    logic [PTR_BITS-1:0]   readPtr;
    logic [PTR_BITS-1:0]   writePtr;
    logic [COUNT_BITS-1:0] count;
    logic                  doPush;
    logic                  doPop;

    // Requests against a full or empty queue are dropped
    assign doPush = push && !full;
    assign doPop  = pop && !empty;

    assign full    = (count == COUNT_BITS'(DEPTH));
    assign empty   = (count == '0);
    assign popData = entries[readPtr];

    // Entry storage
    always_ff @(posedge CLK) begin
        if (doPush) begin
            entries[writePtr] <= pushData;
        end
    end

    // ------------------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------------------
    always_ff @(posedge CLK) begin
        if (reset) begin
            readPtr  <= '0;
            writePtr <= '0;
            count    <= '0;
        end else begin
            if (doPush) begin
                writePtr <= (writePtr == LAST_PTR) ? '0 : writePtr + 1'b1;
            end
            if (doPop) begin
                readPtr <= (readPtr == LAST_PTR) ? '0 : readPtr + 1'b1;
            end
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/registerAliasTable.sv
`timescale 1ns/10ps
`default_nettype none
`include "rename_defines.svh"

module registerAliasTable (
    input  wire logic                CLK,
    input  wire logic                reset,
    input  wire renamePkg::archReg_t archA,
    input  wire renamePkg::archReg_t archB,
    input  wire renamePkg::archReg_t archDst,
    output renamePkg::physReg_t      physA,
    output renamePkg::physReg_t      physB,
    output renamePkg::physReg_t      physOld,
    input  wire logic                update,
    input  wire renamePkg::physReg_t newPhys
);

    import renamePkg::*;

    physReg_t mapTable [`NUM_ARCH_REGS];

    // Entry 0 keeps physical 0, so $zero reads back as 0
    assign physA   = mapTable[archA];
    assign physB   = mapTable[archB];
    assign physOld = mapTable[archDst];

    // ------------------------------------------------------------------------
    // Identity mapping out of reset and at most one write per cycle
    // ------------------------------------------------------------------------
    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
                mapTable[i] <= physReg_t'(i);
            end
        end else if (update && archDst != '0) begin
            mapTable[archDst] <= newPhys;
        end
    end

endmodule

`default_nettype wire

// File: rtl/renamePkg.sv
`default_nettype none
`include "rename_defines.svh"

package renamePkg;

    typedef logic [$clog2(`NUM_ARCH_REGS)-1:0] archReg_t;
    typedef logic [`PHYS_BITS-1:0] physReg_t;
    typedef logic [`WORD_WIDTH-1:0] word_t;
    typedef logic [`ALU_CTRL_BITS-1:0] aluCtrl_t;

    // Micro-op as it leaves decode
    typedef struct packed {
        archReg_t srcA;
        archReg_t srcB;
        archReg_t dst;
        logic     regWrite;
        logic     memRead;
        logic     memWrite;
        logic     hasImmediate;
        aluCtrl_t aluControl;
        word_t    immediate;
    } decodedOp_t;

    // Micro-op after renaming as sent to issue or to the LSQ
    typedef struct packed {
        physReg_t physSrcA;
        physReg_t physSrcB;
        physReg_t physDst;
        physReg_t oldPhysDst;
        aluCtrl_t aluControl;
        logic     memRead;
        logic     memWrite;
        logic     hasImmediate;
        word_t    immediate;
    } renamedOp_t;

endpackage

`default_nettype wire

// File: rtl/renameStage.sv
`timescale 1ns/10ps
`default_nettype none

module renameStage (
    input  wire logic                  CLK,
    input  wire logic                  reset,
    // Decode queue head
    input  wire renamePkg::decodedOp_t headOp,
    input  wire logic                  headEmpty,
    output logic                       headPop,
    // Alias table
    input  wire renamePkg::physReg_t   physA,
    input  wire renamePkg::physReg_t   physB,
    input  wire renamePkg::physReg_t   physOld,
    output logic                       tableUpdate,
    // Free list
    input  wire renamePkg::physReg_t   freeReg,
    input  wire logic                  freeEmpty,
    output logic                       allocate,
    // Load/store queue
    input  wire logic                  lsqFull,
    output logic                       lsqPush,
    output renamePkg::renamedOp_t      lsqData,
    // Issue output
    output renamePkg::renamedOp_t      issueOp,
    output logic                       issueValid,
    input  wire logic                  issueWait
);

    import renamePkg::*;

    logic       hasDest;
    logic       isMem;
    logic       stall;
    renamedOp_t renamed;

    assign hasDest = headOp.regWrite && (headOp.dst != '0);
    assign isMem   = headOp.memRead || headOp.memWrite;

    // ------------------------------------------------------------------------
    // Stall rules
    // ------------------------------------------------------------------------
    // Issue register frees up on the same edge its op is taken
    assign stall = (hasDest && freeEmpty) ||
                   (isMem && lsqFull) ||
                   (!isMem && issueValid && issueWait);

    assign headPop     = !headEmpty && !stall;
    assign tableUpdate = headPop && hasDest;
    assign allocate    = headPop && hasDest;
    assign lsqPush     = headPop && isMem;

    // Ops without a destination take no register
    always_comb begin
        renamed.physSrcA     = physA;
        renamed.physSrcB     = physB;
        renamed.physDst      = hasDest ? freeReg : '0;
        renamed.oldPhysDst   = hasDest ? physOld : '0;
        renamed.aluControl   = headOp.aluControl;
        renamed.memRead      = headOp.memRead;
        renamed.memWrite     = headOp.memWrite;
        renamed.hasImmediate = headOp.hasImmediate;
        renamed.immediate    = headOp.immediate;
    end

    assign lsqData = renamed;

    // ------------------------------------------------------------------------
    // Issue output register
    // ------------------------------------------------------------------------
    always_ff @(posedge CLK) begin
        if (reset) begin
            issueValid <= 1'b0;
        end else if (headPop && !isMem) begin
            issueValid <= 1'b1;
        end else if (!issueWait) begin
            issueValid <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (headPop && !isMem) begin
            issueOp <= renamed;
        end
    end

endmodule

`default_nettype wire

// File: rtl/renameUnit.sv
`timescale 1ns/10ps
`default_nettype none
`include "rename_defines.svh"

module renameUnit (
    input  wire logic                  CLK,
    input  wire logic                  reset,
    input  wire renamePkg::decodedOp_t decodeOp,
    input  wire logic                  decodeValid,
    output logic                       decodeWait,
    output renamePkg::renamedOp_t      issueOp,
    output logic                       issueValid,
    input  wire logic                  issueWait,
    output renamePkg::renamedOp_t      lsqOp,
    output logic                       lsqValid,
    input  wire logic                  lsqPop,
    input  wire logic                  retireValid,
    input  wire renamePkg::physReg_t   retireReg
);

    import renamePkg::*;

    decodedOp_t headOp;
    logic       headEmpty;
    logic       headPop;
    physReg_t   physA;
    physReg_t   physB;
    physReg_t   physOld;
    logic       tableUpdate;
    physReg_t   freeReg;
    logic       freeEmpty;
    logic       allocate;
    logic       lsqFull;
    logic       lsqPush;
    renamedOp_t lsqData;
    logic       lsqEmpty;

    // ------------------------------------------------------------------------
    // Decode queue
    // ------------------------------------------------------------------------
    opQueue #(
        .DEPTH(`DECODE_QUEUE_DEPTH),
        .ENTRY_BITS($bits(decodedOp_t))
    ) decodeQueue_i (
        .CLK(CLK),
        .reset(reset),
        .push(decodeValid),
        .pushData(decodeOp),
        .full(decodeWait),
        .pop(headPop),
        .popData(headOp),
        .empty(headEmpty)
    );

    registerAliasTable registerAliasTable_i (
        .CLK(CLK),
        .reset(reset),
        .archA(headOp.srcA),
        .archB(headOp.srcB),
        .archDst(headOp.dst),
        .physA(physA),
        .physB(physB),
        .physOld(physOld),
        .update(tableUpdate),
        .newPhys(freeReg)
    );

    freeList freeList_i (
        .CLK(CLK),
        .reset(reset),
        .allocate(allocate),
        .freeReg(freeReg),
        .empty(freeEmpty),
        .releaseValid(retireValid),
        .releaseReg(retireReg)
    );

    renameStage renameStage_i (
        .CLK(CLK),
        .reset(reset),
        .headOp(headOp),
        .headEmpty(headEmpty),
        .headPop(headPop),
        .physA(physA),
        .physB(physB),
        .physOld(physOld),
        .tableUpdate(tableUpdate),
        .freeReg(freeReg),
        .freeEmpty(freeEmpty),
        .allocate(allocate),
        .lsqFull(lsqFull),
        .lsqPush(lsqPush),
        .lsqData(lsqData),
        .issueOp(issueOp),
        .issueValid(issueValid),
        .issueWait(issueWait)
    );

    // ------------------------------------------------------------------------
    // Load/store queue
    // ------------------------------------------------------------------------
    opQueue #(
        .DEPTH(`LSQ_DEPTH),
        .ENTRY_BITS($bits(renamedOp_t))
    ) lsqQueue_i (
        .CLK(CLK),
        .reset(reset),
        .push(lsqPush),
        .pushData(lsqData),
        .full(lsqFull),
        .pop(lsqPop),
        .popData(lsqOp),
        .empty(lsqEmpty)
    );

    assign lsqValid = !lsqEmpty;

endmodule

`default_nettype wire

// File: rtl/rename_defines.svh
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// Register file sizes
`define NUM_ARCH_REGS 32
`define NUM_PHYS_REGS 64

// Width of a physical register number (log2 of NUM_PHYS_REGS)
`define PHYS_BITS 6

// Datapath field widths
`define WORD_WIDTH 32
`define ALU_CTRL_BITS 6

// Queue depths
`define DECODE_QUEUE_DEPTH 8
`define LSQ_DEPTH 16

`endif

// File: testbench/renameUnitTb.sv
`timescale 1ns/10ps
`default_nettype none
`include "rename_defines.svh"

module renameUnitTb;

    import renamePkg::*;

    localparam int NUM_OPS    = 400;
    localparam int MAX_CYCLES = NUM_OPS * 50;

    logic       CLK;
    logic       reset;
    decodedOp_t decodeOp;
    logic       decodeValid;
    logic       decodeWait;
    renamedOp_t issueOp;
    logic       issueValid;
    logic       issueWait;
    renamedOp_t lsqOp;
    logic       lsqValid;
    logic       lsqPop;
    logic       retireValid;
    physReg_t   retireReg;

    // Reference model state
    physReg_t   modelMap [`NUM_ARCH_REGS];
    physReg_t   modelFree [$];
    decodedOp_t pendingOps [$];
    renamedOp_t expIssue [$];
    renamedOp_t expLsq [$];
    physReg_t   retireQ [$];
    int         seenOps = 0;
    int         cycles = 0;
    logic       sawDecodeWait = 1'b0;

    renameUnit renameUnit_i (
        .CLK(CLK),
        .reset(reset),
        .decodeOp(decodeOp),
        .decodeValid(decodeValid),
        .decodeWait(decodeWait),
        .issueOp(issueOp),
        .issueValid(issueValid),
        .issueWait(issueWait),
        .lsqOp(lsqOp),
        .lsqValid(lsqValid),
        .lsqPop(lsqPop),
        .retireValid(retireValid),
        .retireReg(retireReg)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    task automatic initModel();
        for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
            modelMap[i] = physReg_t'(i);
        end
        modelFree.delete();
        for (int i = `NUM_ARCH_REGS; i < `NUM_PHYS_REGS; i++) begin
            modelFree.push_back(physReg_t'(i));
        end
    endtask

    function automatic logic hasDestination(input decodedOp_t op);
        return op.regWrite && (op.dst != '0);
    endfunction

    // Sources read the mapping before this op's own update
    function automatic renamedOp_t renameRef(input decodedOp_t op);
        renamedOp_t r;
        r.physSrcA = (op.srcA == '0) ? '0 : modelMap[op.srcA];
        r.physSrcB = (op.srcB == '0) ? '0 : modelMap[op.srcB];
        if (hasDestination(op)) begin
            r.physDst        = modelFree.pop_front();
            r.oldPhysDst     = modelMap[op.dst];
            modelMap[op.dst] = r.physDst;
        end else begin
            r.physDst    = '0;
            r.oldPhysDst = '0;
        end
        r.aluControl   = op.aluControl;
        r.memRead      = op.memRead;
        r.memWrite     = op.memWrite;
        r.hasImmediate = op.hasImmediate;
        r.immediate    = op.immediate;
        return r;
    endfunction

    // About 30% memory ops
    // Stores never write a register
    function automatic decodedOp_t randomDecodedOp();
        decodedOp_t op;
        int kind;
        kind            = $urandom_range(99);
        op.srcA         = archReg_t'($urandom_range(`NUM_ARCH_REGS - 1));
        op.srcB         = archReg_t'($urandom_range(`NUM_ARCH_REGS - 1));
        op.dst          = archReg_t'($urandom_range(`NUM_ARCH_REGS - 1));
        if ($urandom_range(9) == 0) begin
            op.dst = '0;
        end
        op.memRead      = (kind < 15);
        op.memWrite     = (kind >= 15) && (kind < 30);
        op.regWrite     = op.memWrite ? 1'b0 : ($urandom_range(9) != 0);
        op.hasImmediate = op.memRead || op.memWrite || ($urandom_range(1) == 1);
        op.aluControl   = aluCtrl_t'($urandom_range(63));
        op.immediate    = word_t'($urandom);
        return op;
    endfunction

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            failRun($sformatf("ERR %0t %s expected %b actual %b", $time, name, expected, actual));
        end
    endtask

    task automatic checkIssue(input renamedOp_t expected, input renamedOp_t actual);
        if (actual !== expected) begin
            failRun($sformatf("ERR %0t issueOp expected %h actual %h", $time, expected, actual));
        end
    endtask

    task automatic checkLsq(input renamedOp_t expected, input renamedOp_t actual);
        if (actual !== expected) begin
            failRun($sformatf("ERR %0t lsqOp expected %h actual %h", $time, expected, actual));
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    initial begin
        int sentOps;
        int stimCycle;
        void'($urandom(32'h90c6));
        sentOps     = 0;
        stimCycle   = 0;
        reset       = 1'b1;
        decodeOp    = '0;
        decodeValid = 1'b0;
        issueWait   = 1'b0;
        lsqPop      = 1'b0;
        retireValid = 1'b0;
        retireReg   = '0;
        initModel();
        repeat (3) @(posedge CLK);
        reset <= 1'b0;
        @(posedge CLK);
        checkFlag("issueValid", 1'b0, issueValid);
        checkFlag("lsqValid", 1'b0, lsqValid);
        checkFlag("decodeWait", 1'b0, decodeWait);
        forever begin
            if (decodeValid && !decodeWait) begin
                sentOps++;
            end
            // Hold a waiting op until the queue takes it
            if (!(decodeValid && decodeWait)) begin
                if (sentOps < NUM_OPS && $urandom_range(99) < 75) begin
                    decodeOp    <= randomDecodedOp();
                    decodeValid <= 1'b1;
                end else begin
                    decodeValid <= 1'b0;
                end
            end
            issueWait <= ($urandom_range(99) < 40);
            lsqPop    <= ($urandom_range(99) < 60);
            // No retirement for a while so the free list runs dry
            if (retireQ.size() > 0 && (stimCycle < 100 || stimCycle >= 300) &&
                $urandom_range(99) < 70) begin
                retireReg   <= retireQ.pop_front();
                retireValid <= 1'b1;
            end else begin
                retireValid <= 1'b0;
            end
            @(posedge CLK);
            stimCycle++;
        end
    end

    // Samples between edges what the next rising edge will do
    always @(negedge CLK) begin
        renamedOp_t expected;
        if (!reset) begin
            if (decodeWait) begin
                sawDecodeWait = 1'b1;
            end
            if (decodeValid && !decodeWait) begin
                pendingOps.push_back(decodeOp);
            end
            if (retireValid) begin
                modelFree.push_back(retireReg);
            end
            while (pendingOps.size() > 0 &&
                   (!hasDestination(pendingOps[0]) || modelFree.size() > 0)) begin
                expected = renameRef(pendingOps.pop_front());
                if (expected.memRead || expected.memWrite) begin
                    expLsq.push_back(expected);
                end else begin
                    expIssue.push_back(expected);
                end
            end
            if (issueValid && !issueWait) begin
                if (expIssue.size() == 0) begin
                    failRun($sformatf("Issue output gave an op that was never sent at %0t",
                                      $time));
                end
                expected = expIssue.pop_front();
                checkIssue(expected, issueOp);
                if (expected.oldPhysDst != '0) begin
                    retireQ.push_back(expected.oldPhysDst);
                end
                seenOps++;
            end
            if (lsqValid && lsqPop) begin
                if (expLsq.size() == 0) begin
                    failRun($sformatf("Load/store output gave an op that was never sent at %0t",
                                      $time));
                end
                expected = expLsq.pop_front();
                checkLsq(expected, lsqOp);
                if (expected.oldPhysDst != '0) begin
                    retireQ.push_back(expected.oldPhysDst);
                end
                seenOps++;
            end
        end
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            failRun($sformatf("Timed out after %0d cycles with %0d of %0d ops seen",
                              cycles, seenOps, NUM_OPS));
        end
    end

    initial begin
        wait (seenOps == NUM_OPS);
        repeat (20) @(posedge CLK);
        if (!sawDecodeWait) begin
            failRun("decodeWait never rose, so the free-list stall was not reached");
        end else if (expIssue.size() != 0 || expLsq.size() != 0 || pendingOps.size() != 0) begin
            failRun("Some renamed ops never left the DUT");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire
